// File: Bender.yml
package:
  name: vec_core

sources:
  - vec_pkg.sv
  - vec_decoder.sv
  - vec_register_file.sv
  - vec_dispatch.sv
  - vec_lane.sv
  - vec_writeback.sv
  - vec_core.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - vec_core_assert.sv
      - tb_vec_core.sv

// File: list.f
vec_pkg.sv
vec_decoder.sv
vec_register_file.sv
vec_dispatch.sv
vec_lane.sv
vec_writeback.sv
vec_core.sv
tb_clock_gen.sv
vec_core_assert.sv
tb_vec_core.sv

// File: tb_clock_gen.sv
`timescale 1ns/100ps

module tb_clock_gen #(
    parameter int period_ns    = 10,
    parameter int reset_cycles = 2
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(period_ns / 2.0) clk = ~clk;
    end

    // active low, released just after an edge
    initial begin
        rst = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        #1 rst = 1'b1;
    end

endmodule

// File: tb_vec_core.sv
`timescale 1ns/100ps

module tb_vec_core;

    localparam int num_lanes  = 8;
    localparam int period_ns  = 10;
    localparam int num_instrs = 3000;
    localparam int timeout_ns = (num_instrs + 64) * period_ns;

    typedef vec_pkg::elem_t [num_lanes-1:0] vreg_t;

    logic                 clk;
    logic                 rst;
    logic                 instr_valid;
    vec_pkg::instr_t      instr;
    vec_pkg::scalar_t     scalar;
    vec_pkg::scalar_t     vl;
    logic                 wb_valid;
    vec_pkg::vreg_idx_t   wb_rd;
    vreg_t                wb_data;

    // reference model state
    vreg_t                model_regs [32];
    vec_pkg::scalar_t     model_vl;
    vec_pkg::vreg_idx_t   exp_rd_q [$];
    vreg_t                exp_data_q [$];

    logic [31:0]          seed = 32'h1ab7_fcec;
    int                   mismatches = 0;
    int                   other_errors = 0;
    int                   checked = 0;
    bit                   timed_out = 1'b0;

    tb_clock_gen #(.period_ns(period_ns), .reset_cycles(2)) clock_gen_i (
        .clk (clk),
        .rst (rst)
    );

    vec_core #(.num_lanes(num_lanes)) dut_i (
        .clk         (clk),
        .rst         (rst),
        .instr_valid (instr_valid),
        .instr       (instr),
        .scalar      (scalar),
        .vl          (vl),
        .wb_valid    (wb_valid),
        .wb_rd       (wb_rd),
        .wb_data     (wb_data)
    );

    // ------------------------------------------------------------------------
    // random stimulus
    // ------------------------------------------------------------------------
    function logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    // mostly v0..v3 so that hazards and mask updates happen often
    function automatic vec_pkg::vreg_idx_t pick_reg();
        logic [31:0] r;
        r = next_rand();
        if (r[31:30] == 2'd0) begin
            return r[29:25];
        end
        return {3'b000, r[29:28]};
    endfunction

    function automatic vec_pkg::instr_t random_arith();
        logic [31:0] r;
        logic [5:0]  f6;
        logic [2:0]  f3;
        r = next_rand();
        case (r[31:29])
            3'd0:    f6 = vec_pkg::funct6_add;
            3'd1:    f6 = vec_pkg::funct6_sub;
            3'd2:    f6 = vec_pkg::funct6_minu;
            3'd3:    f6 = vec_pkg::funct6_maxu;
            3'd4:    f6 = vec_pkg::funct6_and;
            3'd5:    f6 = vec_pkg::funct6_or;
            3'd6:    f6 = vec_pkg::funct6_xor;
            default: f6 = r[20:15];
        endcase
        if (r[28:26] < 3'd3) begin
            f3 = vec_pkg::funct3_ivv;
        end else if (r[28:26] < 3'd6) begin
            f3 = vec_pkg::funct3_ivx;
        end else begin
            f3 = vec_pkg::funct3_ivi;
        end
        return {f6, r[25], pick_reg(), pick_reg(), f3, pick_reg(), vec_pkg::opcode_op_v};
    endfunction

    function automatic vec_pkg::instr_t illegal_word();
        logic [31:0]     r;
        vec_pkg::instr_t word;
        r = next_rand();
        word = random_arith();
        case (r[31:30])
            2'd0: word[6:0] = 7'b0110011;
            2'd1: word[14:12] = r[29] ? 3'b001 : 3'b101;
            // vsetivli and vsetvl are not kept
            2'd2: begin
                word[31]    = 1'b1;
                word[14:12] = vec_pkg::funct3_cfg;
            end
            default: begin
                word[14:12] = vec_pkg::funct3_ivi;
                case (r[29:28])
                    2'd0:    word[31:26] = vec_pkg::funct6_sub;
                    2'd1:    word[31:26] = vec_pkg::funct6_minu;
                    default: word[31:26] = vec_pkg::funct6_maxu;
                endcase
            end
        endcase
        return word;
    endfunction

    // ------------------------------------------------------------------------
    // reference model
    // ------------------------------------------------------------------------
    function automatic vec_pkg::elem_t alu(input int op, input vec_pkg::elem_t a,
                                           input vec_pkg::elem_t b);
        case (op)
            0:       return a + b;
            1:       return a - b;
            2:       return (a < b) ? a : b;
            3:       return (a > b) ? a : b;
            4:       return a & b;
            5:       return a | b;
            default: return a ^ b;
        endcase
    endfunction

    task automatic apply_model(input vec_pkg::instr_t word, input vec_pkg::scalar_t sc);
        vreg_t          next;
        vec_pkg::elem_t b;
        int             op;
        int             kind;
        logic           active;
        if (word[6:0] != vec_pkg::opcode_op_v) return;
        if (word[14:12] == vec_pkg::funct3_cfg) begin
            if (!word[31]) begin
                if (word[19:15] == 5'd0 || sc > num_lanes) begin
                    model_vl = num_lanes;
                end else begin
                    model_vl = sc;
                end
            end
            return;
        end
        case (word[14:12])
            vec_pkg::funct3_ivv: kind = 0;
            vec_pkg::funct3_ivx: kind = 1;
            vec_pkg::funct3_ivi: kind = 2;
            default:             return;
        endcase
        case (word[31:26])
            vec_pkg::funct6_add:  op = 0;
            vec_pkg::funct6_sub:  op = 1;
            vec_pkg::funct6_minu: op = 2;
            vec_pkg::funct6_maxu: op = 3;
            vec_pkg::funct6_and:  op = 4;
            vec_pkg::funct6_or:   op = 5;
            vec_pkg::funct6_xor:  op = 6;
            default:              return;
        endcase
        if (kind == 2 && op >= 1 && op <= 3) return;
        for (int i = 0; i < num_lanes; i++) begin
            case (kind)
                0:       b = model_regs[word[19:15]][i];
                1:       b = sc;
                default: b = {{27{word[19]}}, word[19:15]};
            endcase
            active = (word[25] || model_regs[0][i][0]) && (i < model_vl);
            next[i] = active ? alu(op, model_regs[word[24:20]][i], b)
                             : model_regs[word[11:7]][i];
        end
        model_regs[word[11:7]] = next;
        exp_rd_q.push_back(word[11:7]);
        exp_data_q.push_back(next);
    endtask

    task automatic drive_next();
        logic [31:0] r;
        r = next_rand();
        scalar = next_rand();
        if (r[31:29] == 3'd0) begin
            instr_valid = 1'b0;
            instr = next_rand();
            return;
        end
        if (r[27:24] < 4'd2) begin
            // vsetvli, requests 0..11 so that the cap and vl of 0 both occur
            scalar = next_rand() % 12;
            instr = {1'b0, r[20:10], r[9] ? 5'd0 : pick_reg(), vec_pkg::funct3_cfg,
                     r[4:0], vec_pkg::opcode_op_v};
        end else if (r[27:24] == 4'd2) begin
            instr = illegal_word();
        end else begin
            instr = random_arith();
        end
        instr_valid = 1'b1;
        apply_model(instr, scalar);
    endtask

    // ------------------------------------------------------------------------
    // checks and end of run
    // ------------------------------------------------------------------------
    task automatic check_vl();
        assert (vl === model_vl)
        else begin
            $display("MISMATCH vl: got %h expected %h", vl, model_vl);
            mismatches++;
        end
    endtask

    always @(negedge clk) begin : check_writeback
        vec_pkg::vreg_idx_t rd_e;
        vreg_t              data_e;
        if (rst && wb_valid === 1'b1) begin
            assert (exp_rd_q.size() != 0)
            else begin
                $display("write-back seen with no instruction outstanding");
                other_errors++;
            end
            if (exp_rd_q.size() != 0) begin
                rd_e = exp_rd_q.pop_front();
                data_e = exp_data_q.pop_front();
                checked++;
                assert (wb_rd === rd_e)
                else begin
                    $display("MISMATCH wb_rd: got %h expected %h", wb_rd, rd_e);
                    mismatches++;
                end
                assert (wb_data === data_e)
                else begin
                    $display("MISMATCH wb_data: got %h expected %h", wb_data, data_e);
                    mismatches++;
                end
            end
        end
    end

    task automatic report_and_finish();
        int failures;
        failures = dut_i.core_assert_i.failures;
        $display("%0d write-backs checked, %0d mismatches, %0d other errors, %0d assertion failures",
                 checked, mismatches, other_errors, failures);
        if (!timed_out && mismatches == 0 && other_errors == 0 && failures == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    endtask

    initial begin : watchdog
        #(timeout_ns);
        $display("timeout, the run did not finish within %0d ns", timeout_ns);
        timed_out = 1'b1;
        report_and_finish();
    end

    initial begin : stimulus
        instr_valid = 1'b0;
        instr       = '0;
        scalar      = '0;
        model_vl    = num_lanes;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        wait (rst === 1'b1);
        for (int n = 0; n < num_instrs; n++) begin
            @(posedge clk);
            #1;
            check_vl();
            drive_next();
        end
        @(posedge clk);
        #1;
        check_vl();
        instr_valid = 1'b0;
        // drain, then idle a few cycles to catch stray write-backs
        while (exp_rd_q.size() != 0) begin
            @(posedge clk);
            #1;
            check_vl();
        end
        repeat (4) begin
            @(posedge clk);
            #1;
            check_vl();
        end
        report_and_finish();
    end

endmodule

// File: vec_core.sv
`timescale 1ns/100ps

module vec_core #(
    parameter int num_lanes = 8
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           instr_valid,
    input  vec_pkg::instr_t                instr,
    input  vec_pkg::scalar_t               scalar,
    output vec_pkg::scalar_t               vl,
    output logic                           wb_valid,
    output vec_pkg::vreg_idx_t             wb_rd,
    output vec_pkg::elem_t [num_lanes-1:0] wb_data
);

    // register file ports
    vec_pkg::vreg_idx_t             rd_idx1;
    vec_pkg::vreg_idx_t             rd_idx2;
    vec_pkg::vreg_idx_t             rd_idx3;
    vec_pkg::elem_t [num_lanes-1:0] rd_data1;
    vec_pkg::elem_t [num_lanes-1:0] rd_data2;
    vec_pkg::elem_t [num_lanes-1:0] rd_data3;
    vec_pkg::elem_t [num_lanes-1:0] v0_data;
    logic                           we;
    vec_pkg::vreg_idx_t             wr_idx;
    vec_pkg::elem_t [num_lanes-1:0] wr_data;

    // issue stage
    logic                           issue_valid;
    vec_pkg::vreg_idx_t             issue_rd;
    vec_pkg::vec_op_e               issue_op;
    vec_pkg::operand_kind_e         issue_kind;
    vec_pkg::elem_t                 issue_operand;
    logic                           issue_vm;
    vec_pkg::scalar_t               issue_vl;
    vec_pkg::elem_t [num_lanes-1:0] issue_vs1;
    vec_pkg::elem_t [num_lanes-1:0] issue_vs2;
    vec_pkg::elem_t [num_lanes-1:0] issue_vd_old;
    vec_pkg::elem_t [num_lanes-1:0] issue_v0;
    logic                           fwd_vs1;
    logic                           fwd_vs2;
    logic                           fwd_vd;
    logic                           fwd_v0;
    vec_pkg::elem_t [num_lanes-1:0] lane_result;

    vec_register_file #(.num_lanes(num_lanes)) register_file_i (
        .clk      (clk),
        .rst      (rst),
        .rd_idx1  (rd_idx1),
        .rd_idx2  (rd_idx2),
        .rd_idx3  (rd_idx3),
        .we       (we),
        .wr_idx   (wr_idx),
        .wr_data  (wr_data),
        .rd_data1 (rd_data1),
        .rd_data2 (rd_data2),
        .rd_data3 (rd_data3),
        .v0_data  (v0_data)
    );

    vec_dispatch #(.num_lanes(num_lanes)) dispatch_i (
        .clk           (clk),
        .rst           (rst),
        .instr_valid   (instr_valid),
        .instr         (instr),
        .scalar        (scalar),
        .rd_data1      (rd_data1),
        .rd_data2      (rd_data2),
        .rd_data3      (rd_data3),
        .v0_data       (v0_data),
        .vl            (vl),
        .rd_idx1       (rd_idx1),
        .rd_idx2       (rd_idx2),
        .rd_idx3       (rd_idx3),
        .issue_valid   (issue_valid),
        .issue_rd      (issue_rd),
        .issue_op      (issue_op),
        .issue_kind    (issue_kind),
        .issue_operand (issue_operand),
        .issue_vm      (issue_vm),
        .issue_vl      (issue_vl),
        .issue_vs1     (issue_vs1),
        .issue_vs2     (issue_vs2),
        .issue_vd_old  (issue_vd_old),
        .issue_v0      (issue_v0),
        .fwd_vs1       (fwd_vs1),
        .fwd_vs2       (fwd_vs2),
        .fwd_vd        (fwd_vd),
        .fwd_v0        (fwd_v0)
    );

    // ------------------------------------------------------------------------
    // one lane per element
    // ------------------------------------------------------------------------
    for (genvar i = 0; i < num_lanes; i++) begin : g_lane
        vec_lane #(.lane_idx(i)) lane_i (
            .clk           (clk),
            .rst           (rst),
            .issue_valid   (issue_valid),
            .issue_op      (issue_op),
            .issue_kind    (issue_kind),
            .issue_operand (issue_operand),
            .issue_vm      (issue_vm),
            .issue_vl      (issue_vl),
            .issue_vs1     (issue_vs1[i]),
            .issue_vs2     (issue_vs2[i]),
            .issue_vd_old  (issue_vd_old[i]),
            .issue_v0      (issue_v0[i]),
            .fwd_vs1       (fwd_vs1),
            .fwd_vs2       (fwd_vs2),
            .fwd_vd        (fwd_vd),
            .fwd_v0        (fwd_v0),
            .result        (lane_result[i])
        );
    end

    vec_writeback #(.num_lanes(num_lanes)) writeback_i (
        .clk         (clk),
        .rst         (rst),
        .issue_valid (issue_valid),
        .issue_rd    (issue_rd),
        .lane_result (lane_result),
        .wb_valid    (wb_valid),
        .wb_rd       (wb_rd),
        .wb_data     (wb_data),
        .we          (we),
        .wr_idx      (wr_idx),
        .wr_data     (wr_data)
    );

endmodule

// File: vec_core_assert.sv
`timescale 1ns/100ps

module vec_core_assert #(
    parameter int num_lanes = 8
) (
    input logic             clk,
    input logic             rst,
    input logic             wb_valid,
    input logic             accepted,
    input vec_pkg::scalar_t vl
);

    int failures = 0;

    wb_valid_known: assert property (@(posedge clk) disable iff (!rst)
        !$isunknown(wb_valid))
        else begin
            failures++;
            $error("wb_valid is unknown after reset");
        end

    vl_in_range: assert property (@(posedge clk) disable iff (!rst)
        vl <= vec_pkg::scalar_t'(num_lanes))
        else begin
            failures++;
            $error("vl exceeds the lane count");
        end

    // dispatch edge, lane edge, then the write-back strobe
    wb_after_accept: assert property (@(posedge clk) disable iff (!rst)
        accepted |-> ##2 wb_valid)
        else begin
            failures++;
            $error("no write-back two edges after an accepted instruction");
        end

    wb_has_source: assert property (@(posedge clk) disable iff (!rst)
        wb_valid |-> $past(accepted, 2))
        else begin
            failures++;
            $error("write-back without an accepted instruction two edges before");
        end

endmodule

bind vec_core vec_core_assert #(.num_lanes(num_lanes)) core_assert_i (
    .clk      (clk),
    .rst      (rst),
    .wb_valid (wb_valid),
    .accepted (dispatch_i.accept),
    .vl       (vl)
);

// File: vec_decoder.sv
`timescale 1ns/100ps

module vec_decoder (
    input  vec_pkg::instr_t        instr,
    output logic                   legal,
    output logic                   is_cfg,
    output vec_pkg::vec_op_e       op,
    output vec_pkg::operand_kind_e kind,
    output vec_pkg::vreg_idx_t     vs1,
    output vec_pkg::vreg_idx_t     vs2,
    output vec_pkg::vreg_idx_t     vd,
    output logic                   vm,
    output vec_pkg::elem_t         imm
);

    logic [5:0] funct6;
    logic [2:0] funct3;
    logic       is_op_v;
    logic       op_known;
    logic       form_known;
    logic       imm_ok;

    // instruction fields
    assign funct6  = instr[31:26];
    assign funct3  = instr[14:12];
    assign vm      = instr[25];
    assign vs2     = instr[24:20];
    assign vs1     = instr[19:15];
    assign vd      = instr[11:7];
    assign imm     = {{(vec_pkg::elen-5){instr[19]}}, instr[19:15]};
    assign is_op_v = instr[6:0] == vec_pkg::opcode_op_v;

    // vsetvli only, vsetivli and vsetvl both have bit 31 set
    assign is_cfg = is_op_v && (funct3 == vec_pkg::funct3_cfg) && !instr[31];

    always_comb begin
        op_known = 1'b1;
        op       = vec_pkg::op_add;
        case (funct6)
            vec_pkg::funct6_add:  op = vec_pkg::op_add;
            vec_pkg::funct6_sub:  op = vec_pkg::op_sub;
            vec_pkg::funct6_minu: op = vec_pkg::op_minu;
            vec_pkg::funct6_maxu: op = vec_pkg::op_maxu;
            vec_pkg::funct6_and:  op = vec_pkg::op_and;
            vec_pkg::funct6_or:   op = vec_pkg::op_or;
            vec_pkg::funct6_xor:  op = vec_pkg::op_xor;
            default:              op_known = 1'b0;
        endcase
    end

    always_comb begin
        form_known = 1'b1;
        kind       = vec_pkg::kind_vv;
        case (funct3)
            vec_pkg::funct3_ivv: kind = vec_pkg::kind_vv;
            vec_pkg::funct3_ivx: kind = vec_pkg::kind_vx;
            vec_pkg::funct3_ivi: kind = vec_pkg::kind_vi;
            default:             form_known = 1'b0;
        endcase
    end

    // no .vi form of sub, minu, maxu
    assign imm_ok = (kind != vec_pkg::kind_vi) ||
                    (op inside {vec_pkg::op_add, vec_pkg::op_and,
                                vec_pkg::op_or, vec_pkg::op_xor});

    assign legal = is_cfg || (is_op_v && op_known && form_known && imm_ok);

endmodule

// File: vec_dispatch.sv
`timescale 1ns/100ps

module vec_dispatch #(
    parameter int num_lanes = 8
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           instr_valid,
    input  vec_pkg::instr_t                instr,
    input  vec_pkg::scalar_t               scalar,
    input  vec_pkg::elem_t [num_lanes-1:0] rd_data1,
    input  vec_pkg::elem_t [num_lanes-1:0] rd_data2,
    input  vec_pkg::elem_t [num_lanes-1:0] rd_data3,
    input  vec_pkg::elem_t [num_lanes-1:0] v0_data,
    output vec_pkg::scalar_t               vl,
    output vec_pkg::vreg_idx_t             rd_idx1,
    output vec_pkg::vreg_idx_t             rd_idx2,
    output vec_pkg::vreg_idx_t             rd_idx3,
    output logic                           issue_valid,
    output vec_pkg::vreg_idx_t             issue_rd,
    output vec_pkg::vec_op_e               issue_op,
    output vec_pkg::operand_kind_e         issue_kind,
    output vec_pkg::elem_t                 issue_operand,
    output logic                           issue_vm,
    output vec_pkg::scalar_t               issue_vl,
    output vec_pkg::elem_t [num_lanes-1:0] issue_vs1,
    output vec_pkg::elem_t [num_lanes-1:0] issue_vs2,
    output vec_pkg::elem_t [num_lanes-1:0] issue_vd_old,
    output vec_pkg::elem_t [num_lanes-1:0] issue_v0,
    output logic                           fwd_vs1,
    output logic                           fwd_vs2,
    output logic                           fwd_vd,
    output logic                           fwd_v0
);

    logic                   dec_legal;
    logic                   dec_is_cfg;
    vec_pkg::vec_op_e       dec_op;
    vec_pkg::operand_kind_e dec_kind;
    vec_pkg::vreg_idx_t     dec_vs1;
    vec_pkg::vreg_idx_t     dec_vs2;
    vec_pkg::vreg_idx_t     dec_vd;
    logic                   dec_vm;
    vec_pkg::elem_t         dec_imm;
    logic                   accept;
    logic                   cfg_write;
    vec_pkg::scalar_t       new_vl;

    vec_decoder decoder_i (
        .instr  (instr),
        .legal  (dec_legal),
        .is_cfg (dec_is_cfg),
        .op     (dec_op),
        .kind   (dec_kind),
        .vs1    (dec_vs1),
        .vs2    (dec_vs2),
        .vd     (dec_vd),
        .vm     (dec_vm),
        .imm    (dec_imm)
    );

    assign rd_idx1 = dec_vs1;
    assign rd_idx2 = dec_vs2;
    assign rd_idx3 = dec_vd;

    assign accept    = instr_valid && dec_legal && !dec_is_cfg;
    assign cfg_write = instr_valid && dec_is_cfg;

    // requested length capped at the lane count, rs1 = x0 asks for the max
    always_comb begin
        if (dec_vs1 == '0) begin
            new_vl = vec_pkg::scalar_t'(num_lanes);
        end else if (scalar > vec_pkg::scalar_t'(num_lanes)) begin
            new_vl = vec_pkg::scalar_t'(num_lanes);
        end else begin
            new_vl = scalar;
        end
    end

    // ------------------------------------------------------------------------
    // control: vl csr, issue strobe, bypass flags
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst) begin
            vl          <= vec_pkg::scalar_t'(num_lanes);
            issue_valid <= 1'b0;
            fwd_vs1     <= 1'b0;
            fwd_vs2     <= 1'b0;
            fwd_vd      <= 1'b0;
            fwd_v0      <= 1'b0;
        end else begin
            issue_valid <= accept;
            if (cfg_write) begin
                vl <= new_vl;
            end
            // the held instruction's result is still in the lanes
            if (accept) begin
                fwd_vs1 <= issue_valid && (issue_rd == dec_vs1);
                fwd_vs2 <= issue_valid && (issue_rd == dec_vs2);
                fwd_vd  <= issue_valid && (issue_rd == dec_vd);
                fwd_v0  <= issue_valid && (issue_rd == '0);
            end
        end
    end

    // operand capture
    always_ff @(posedge clk) begin
        if (accept) begin
            issue_rd      <= dec_vd;
            issue_op      <= dec_op;
            issue_kind    <= dec_kind;
            issue_operand <= (dec_kind == vec_pkg::kind_vx) ? scalar : dec_imm;
            issue_vm      <= dec_vm;
            issue_vl      <= vl;
            issue_vs1     <= rd_data1;
            issue_vs2     <= rd_data2;
            issue_vd_old  <= rd_data3;
            issue_v0      <= v0_data;
        end
    end

endmodule

// File: vec_lane.sv
`timescale 1ns/100ps

module vec_lane #(
    parameter int lane_idx = 0
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   issue_valid,
    input  vec_pkg::vec_op_e       issue_op,
    input  vec_pkg::operand_kind_e issue_kind,
    input  vec_pkg::elem_t         issue_operand,
    input  logic                   issue_vm,
    input  vec_pkg::scalar_t       issue_vl,
    input  vec_pkg::elem_t         issue_vs1,
    input  vec_pkg::elem_t         issue_vs2,
    input  vec_pkg::elem_t         issue_vd_old,
    input  vec_pkg::elem_t         issue_v0,
    input  logic                   fwd_vs1,
    input  logic                   fwd_vs2,
    input  logic                   fwd_vd,
    input  logic                   fwd_v0,
    output vec_pkg::elem_t         result
);

    vec_pkg::elem_t vs1;
    vec_pkg::elem_t vs2;
    vec_pkg::elem_t vd_old;
    vec_pkg::elem_t v0;
    vec_pkg::elem_t opnd_b;
    vec_pkg::elem_t alu_out;
    logic           active;

    // back-to-back dependency, take the previous result of this lane
    assign vs1    = fwd_vs1 ? result : issue_vs1;
    assign vs2    = fwd_vs2 ? result : issue_vs2;
    assign vd_old = fwd_vd  ? result : issue_vd_old;
    assign v0     = fwd_v0  ? result : issue_v0;

    assign opnd_b = (issue_kind == vec_pkg::kind_vv) ? vs1 : issue_operand;

    // vd = vs2 op (vs1 | rs1 | imm)
    always_comb begin
        case (issue_op)
            vec_pkg::op_add:  alu_out = vs2 + opnd_b;
            vec_pkg::op_sub:  alu_out = vs2 - opnd_b;
            vec_pkg::op_minu: alu_out = (vs2 < opnd_b) ? vs2 : opnd_b;
            vec_pkg::op_maxu: alu_out = (vs2 > opnd_b) ? vs2 : opnd_b;
            vec_pkg::op_and:  alu_out = vs2 & opnd_b;
            vec_pkg::op_or:   alu_out = vs2 | opnd_b;
            vec_pkg::op_xor:  alu_out = vs2 ^ opnd_b;
            default:          alu_out = vd_old;
        endcase
    end

    // mask bit is the lsb of this lane's v0 element; tail lanes are undisturbed
    assign active = (issue_vm || v0[0]) && (vec_pkg::scalar_t'(lane_idx) < issue_vl);

    always_ff @(posedge clk) begin
        if (!rst) begin
            result <= '0;
        end else if (issue_valid) begin
            result <= active ? alu_out : vd_old;
        end
    end

endmodule

// File: vec_pkg.sv
package vec_pkg;

    // ------------------------------------------------------------------------
    // widths and typed vectors
    // ------------------------------------------------------------------------
    localparam int elen      = 32;
    localparam int num_vregs = 32;

    typedef logic [elen-1:0] elem_t;
    typedef logic [31:0]     scalar_t;
    typedef logic [31:0]     instr_t;
    typedef logic [4:0]      vreg_idx_t;

    // ------------------------------------------------------------------------
    // encodings
    // ------------------------------------------------------------------------
    localparam logic [6:0] opcode_op_v = 7'b1010111;

    // operand form, or vset* when funct3 is all ones
    localparam logic [2:0] funct3_ivv = 3'b000;
    localparam logic [2:0] funct3_ivx = 3'b100;
    localparam logic [2:0] funct3_ivi = 3'b011;
    localparam logic [2:0] funct3_cfg = 3'b111;

    localparam logic [5:0] funct6_add  = 6'b000000;
    localparam logic [5:0] funct6_sub  = 6'b000010;
    localparam logic [5:0] funct6_minu = 6'b000100;
    localparam logic [5:0] funct6_maxu = 6'b000110;
    localparam logic [5:0] funct6_and  = 6'b001001;
    localparam logic [5:0] funct6_or   = 6'b001010;
    localparam logic [5:0] funct6_xor  = 6'b001011;

    typedef enum logic [2:0] {
        op_add,
        op_sub,
        op_minu,
        op_maxu,
        op_and,
        op_or,
        op_xor
    } vec_op_e;

    // where the second operand comes from
    typedef enum logic [1:0] {
        kind_vv,
        kind_vx,
        kind_vi
    } operand_kind_e;

endpackage

// File: vec_register_file.sv
`timescale 1ns/100ps

module vec_register_file #(
    parameter int num_lanes = 8
) (
    input  logic                             clk,
    input  logic                             rst,
    input  vec_pkg::vreg_idx_t               rd_idx1,
    input  vec_pkg::vreg_idx_t               rd_idx2,
    input  vec_pkg::vreg_idx_t               rd_idx3,
    input  logic                             we,
    input  vec_pkg::vreg_idx_t               wr_idx,
    input  vec_pkg::elem_t [num_lanes-1:0]   wr_data,
    output vec_pkg::elem_t [num_lanes-1:0]   rd_data1,
    output vec_pkg::elem_t [num_lanes-1:0]   rd_data2,
    output vec_pkg::elem_t [num_lanes-1:0]   rd_data3,
    output vec_pkg::elem_t [num_lanes-1:0]   v0_data
);

    typedef vec_pkg::elem_t [num_lanes-1:0] vreg_t;

    vreg_t regs [vec_pkg::num_vregs];

    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int i = 0; i < vec_pkg::num_vregs; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[wr_idx] <= wr_data;
        end
    end

    // write-through so a read two behind the writer sees the new value
    function automatic vreg_t read_port(input vec_pkg::vreg_idx_t idx);
        if (we && (wr_idx == idx)) begin
            return wr_data;
        end
        return regs[idx];
    endfunction

    always_comb begin
        rd_data1 = read_port(rd_idx1);
        rd_data2 = read_port(rd_idx2);
        rd_data3 = read_port(rd_idx3);
        v0_data  = read_port('0);
    end

endmodule

// File: vec_writeback.sv
`timescale 1ns/100ps

module vec_writeback #(
    parameter int num_lanes = 8
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           issue_valid,
    input  vec_pkg::vreg_idx_t             issue_rd,
    input  vec_pkg::elem_t [num_lanes-1:0] lane_result,
    output logic                           wb_valid,
    output vec_pkg::vreg_idx_t             wb_rd,
    output vec_pkg::elem_t [num_lanes-1:0] wb_data,
    output logic                           we,
    output vec_pkg::vreg_idx_t             wr_idx,
    output vec_pkg::elem_t [num_lanes-1:0] wr_data
);

    logic               valid_q;
    vec_pkg::vreg_idx_t rd_q;

    // stage register in step with the lane result registers
    always_ff @(posedge clk) begin
        if (!rst) begin
            valid_q <= 1'b0;
            rd_q    <= '0;
        end else begin
            valid_q <= issue_valid;
            if (issue_valid) begin
                rd_q <= issue_rd;
            end
        end
    end

    assign wb_valid = valid_q;
    assign wb_rd    = rd_q;
    assign wb_data  = lane_result;

    // write lands on the next edge
    assign we      = valid_q;
    assign wr_idx  = rd_q;
    assign wr_data = lane_result;

endmodule
